//--- Bender.yml
package:
  name: dfdLite

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dfdPkg.sv
      - hdl/dfdRegs.sv
      - hdl/dbgMuxSel.sv
      - hdl/logicAnalyzer.sv
      - hdl/traceBuffer.sv
      - hdl/dfdTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tbClock.sv
      - verification/dfdTopTb.sv

//--- dfdLite.f
+incdir+hdl
hdl/dfdPkg.sv
hdl/dfdRegs.sv
hdl/dbgMuxSel.sv
hdl/logicAnalyzer.sv
hdl/traceBuffer.sv
hdl/dfdTop.sv
verification/tbClock.sv
verification/dfdTopTb.sv

//--- hdl/dbgMuxSel.sv
// ********************
// dfdLite debug mux
// ********************

`include "dfdLite_params.svh"

module dbgMuxSel
  import dfdPkg::*;
(
  input  logic                         clk,
  input  logic                         i_rst,
  input  hwGroup_t [`DFD_NUM_HW-1:0]   i_hw,
  input  logic [`DFD_SEL_WIDTH-1:0]    i_lane0Sel,
  input  logic [`DFD_SEL_WIDTH-1:0]    i_lane1Sel,
  output debugBus_t                    o_debugBus
);

  hwGroup_t lane0Group;
  hwGroup_t lane1Group;

  // group picked by each selector
  always_comb begin
    lane0Group = i_hw[i_lane0Sel];
    lane1Group = i_hw[i_lane1Sel];
  end

  // one register stage on the bus
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_debugBus <= '0;
    end else begin
      o_debugBus[`DFD_HW_WIDTH-1:0]               <= lane0Group;
      o_debugBus[2*`DFD_HW_WIDTH-1:`DFD_HW_WIDTH] <= lane1Group;
    end
  end

endmodule

//--- hdl/dfdLite_params.svh
// ********************
// dfdLite parameters
// ********************

`ifndef DFDLITE_PARAMS_SVH
`define DFDLITE_PARAMS_SVH

// apb
`define DFD_APB_ADDR_WIDTH 12
`define DFD_APB_DATA_WIDTH 32

// signal groups and debug bus lanes
`define DFD_NUM_HW 16
`define DFD_HW_WIDTH 16
`define DFD_SEL_WIDTH 4

// trace storage
`define DFD_TSTAMP_WIDTH 16
`define DFD_TRACE_DEPTH 64
`define DFD_PTR_WIDTH 6

// register byte offsets
`define DFD_REG_MUXSEL 12'h000
`define DFD_REG_LACTRL 12'h004
`define DFD_REG_STARTMASK 12'h008
`define DFD_REG_STARTMATCH 12'h00C
`define DFD_REG_STOPMASK 12'h010
`define DFD_REG_STOPMATCH 12'h014
`define DFD_REG_LASTATUS 12'h018
`define DFD_REG_TRSTATUS 12'h01C
`define DFD_REG_RDPTR 12'h020
`define DFD_REG_TRDATA 12'h024
`define DFD_REG_TRTSTAMP 12'h028

`endif

//--- hdl/dfdPkg.sv
// ********************
// dfdLite shared types
// ********************

`include "dfdLite_params.svh"

package dfdPkg;

  // one hardware signal group
  typedef logic [`DFD_HW_WIDTH-1:0] hwGroup_t;

  // selected bus, lane 0 in the low half, lane 1 in the high half
  typedef logic [2*`DFD_HW_WIDTH-1:0] debugBus_t;

  // tick count
  typedef logic [`DFD_TSTAMP_WIDTH-1:0] timestamp_t;

  // one trace memory entry
  typedef struct packed {
    timestamp_t stamp;
    debugBus_t  sample;
  } traceEntry_t;

  // logic analyzer FSM states
  typedef enum logic [1:0] {
    LA_IDLE    = 2'd0,
    LA_ARMED   = 2'd1,
    LA_TRACING = 2'd2,
    LA_DONE    = 2'd3
  } laState_e;

endpackage

//--- hdl/dfdRegs.sv
// ********************
// dfdLite APB registers
// ********************

`include "dfdLite_params.svh"

module dfdRegs
  import dfdPkg::*;
(
  input  logic                           clk,
  input  logic                           i_rst,
  // apb slave
  input  logic [`DFD_APB_ADDR_WIDTH-1:0] i_paddr,
  input  logic                           i_psel,
  input  logic                           i_penable,
  input  logic                           i_pwrite,
  input  logic [`DFD_APB_DATA_WIDTH-1:0] i_pwdata,
  output logic                           o_pready,
  output logic [`DFD_APB_DATA_WIDTH-1:0] o_prdata,
  output logic                           o_pslverr,
  // status in
  input  laState_e                       i_laState,
  input  logic [`DFD_PTR_WIDTH:0]        i_wrCount,
  input  logic                           i_full,
  input  traceEntry_t                    i_rdEntry,
  input  logic [`DFD_PTR_WIDTH-1:0]      i_rdPtrValue,
  // configuration out
  output logic [`DFD_SEL_WIDTH-1:0]      o_lane0Sel,
  output logic [`DFD_SEL_WIDTH-1:0]      o_lane1Sel,
  output logic                           o_arm,
  output logic                           o_clear,
  output debugBus_t                      o_startMask,
  output debugBus_t                      o_startMatch,
  output debugBus_t                      o_stopMask,
  output debugBus_t                      o_stopMatch,
  output logic [`DFD_PTR_WIDTH-1:0]      o_rdPtr,
  output logic                           o_rdLoad,
  output logic                           o_rdAdvance
);

  logic                           accessPhase;
  logic                           wrEn;
  logic                           rdCapture;
  logic                           rdReady;
  logic                           addrHit;
  logic                           roHit;
  logic [`DFD_APB_DATA_WIDTH-1:0] rdMux;

  // ********************
  // apb handshake
  // ********************

  assign accessPhase = i_psel & i_penable;
  assign wrEn        = accessPhase & i_pwrite;
  // first access cycle of a read, data gets registered here
  assign rdCapture   = accessPhase & ~i_pwrite & ~rdReady;

  assign o_pready  = accessPhase & (i_pwrite | rdReady);
  assign o_pslverr = o_pready & (~addrHit | (i_pwrite & roHit));

  // offset decode and read mux
  always_comb begin
    addrHit = 1'b1;
    roHit   = 1'b0;
    rdMux   = '0;
    case (i_paddr)
      `DFD_REG_MUXSEL: begin
        rdMux[`DFD_SEL_WIDTH-1:0]                = o_lane0Sel;
        rdMux[2*`DFD_SEL_WIDTH-1:`DFD_SEL_WIDTH] = o_lane1Sel;
      end
      // arm and clear are action bits, read as zero
      `DFD_REG_LACTRL:     rdMux = '0;
      `DFD_REG_STARTMASK:  rdMux = o_startMask;
      `DFD_REG_STARTMATCH: rdMux = o_startMatch;
      `DFD_REG_STOPMASK:   rdMux = o_stopMask;
      `DFD_REG_STOPMATCH:  rdMux = o_stopMatch;
      `DFD_REG_LASTATUS: begin
        rdMux[1:0] = i_laState;
        roHit      = 1'b1;
      end
      `DFD_REG_TRSTATUS: begin
        rdMux[`DFD_PTR_WIDTH:0] = i_wrCount;
        rdMux[8]                = i_full;
        roHit                   = 1'b1;
      end
      `DFD_REG_RDPTR: rdMux[`DFD_PTR_WIDTH-1:0] = i_rdPtrValue;
      `DFD_REG_TRDATA: begin
        rdMux = i_rdEntry.sample;
        roHit = 1'b1;
      end
      `DFD_REG_TRTSTAMP: begin
        rdMux[`DFD_TSTAMP_WIDTH-1:0] = i_rdEntry.stamp;
        roHit                        = 1'b1;
      end
      default: addrHit = 1'b0;
    endcase
  end

  // ********************
  // configuration state
  // ********************

  always_ff @(posedge clk) begin
    if (i_rst) begin
      rdReady      <= 1'b0;
      o_arm        <= 1'b0;
      o_clear      <= 1'b0;
      o_rdLoad     <= 1'b0;
      o_rdAdvance  <= 1'b0;
      o_lane0Sel   <= '0;
      o_lane1Sel   <= '0;
      o_startMask  <= '0;
      o_startMatch <= '0;
      o_stopMask   <= '0;
      o_stopMatch  <= '0;
    end else begin
      rdReady     <= rdCapture;
      o_arm       <= wrEn & (i_paddr == `DFD_REG_LACTRL) & i_pwdata[0];
      o_clear     <= wrEn & (i_paddr == `DFD_REG_LACTRL) & i_pwdata[1];
      o_rdLoad    <= wrEn & (i_paddr == `DFD_REG_RDPTR);
      // pointer moves once the sample has been captured
      o_rdAdvance <= rdCapture & (i_paddr == `DFD_REG_TRDATA);
      if (wrEn) begin
        case (i_paddr)
          `DFD_REG_MUXSEL: begin
            o_lane0Sel <= i_pwdata[`DFD_SEL_WIDTH-1:0];
            o_lane1Sel <= i_pwdata[2*`DFD_SEL_WIDTH-1:`DFD_SEL_WIDTH];
          end
          `DFD_REG_STARTMASK:  o_startMask  <= i_pwdata;
          `DFD_REG_STARTMATCH: o_startMatch <= i_pwdata;
          `DFD_REG_STOPMASK:   o_stopMask   <= i_pwdata;
          `DFD_REG_STOPMATCH:  o_stopMatch  <= i_pwdata;
          default: ;
        endcase
      end
    end
  end

  // read data and pointer load value
  always_ff @(posedge clk) begin
    if (rdCapture) begin
      o_prdata <= rdMux;
    end
    if (wrEn && (i_paddr == `DFD_REG_RDPTR)) begin
      o_rdPtr <= i_pwdata[`DFD_PTR_WIDTH-1:0];
    end
  end

  // response only inside an access phase
  apbReadyInAccess : assert property (
    @(posedge clk) disable iff (i_rst) o_pready |-> (i_psel && i_penable)
  );

endmodule

//--- hdl/dfdTop.sv
// ********************
// dfdLite top
// ********************

`include "dfdLite_params.svh"

module dfdTop
  import dfdPkg::*;
(
  input  logic                           clk,
  input  logic                           i_rst,
  input  hwGroup_t [`DFD_NUM_HW-1:0]     i_hw,
  input  logic                           i_timeTick,
  // apb
  input  logic [`DFD_APB_ADDR_WIDTH-1:0] i_paddr,
  input  logic                           i_psel,
  input  logic                           i_penable,
  input  logic                           i_pwrite,
  input  logic [`DFD_APB_DATA_WIDTH-1:0] i_pwdata,
  output logic                           o_pready,
  output logic [`DFD_APB_DATA_WIDTH-1:0] o_prdata,
  output logic                           o_pslverr,
  // trace status
  output logic                           o_traceActive,
  output logic                           o_triggerOut
);

  logic [`DFD_SEL_WIDTH-1:0] lane0Sel;
  logic [`DFD_SEL_WIDTH-1:0] lane1Sel;
  logic                      arm;
  logic                      clear;
  debugBus_t                 startMask;
  debugBus_t                 startMatch;
  debugBus_t                 stopMask;
  debugBus_t                 stopMatch;
  logic [`DFD_PTR_WIDTH-1:0] rdPtrLoad;
  logic                      rdLoad;
  logic                      rdAdvance;
  logic [`DFD_PTR_WIDTH-1:0] rdPtrValue;
  logic [`DFD_PTR_WIDTH:0]   wrCount;
  logic                      full;
  traceEntry_t               rdEntry;
  debugBus_t                 debugBus;
  laState_e                  laState;

  dfdRegs u_dfdRegs (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_paddr      (i_paddr),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_pwdata     (i_pwdata),
    .o_pready     (o_pready),
    .o_prdata     (o_prdata),
    .o_pslverr    (o_pslverr),
    .i_laState    (laState),
    .i_wrCount    (wrCount),
    .i_full       (full),
    .i_rdEntry    (rdEntry),
    .i_rdPtrValue (rdPtrValue),
    .o_lane0Sel   (lane0Sel),
    .o_lane1Sel   (lane1Sel),
    .o_arm        (arm),
    .o_clear      (clear),
    .o_startMask  (startMask),
    .o_startMatch (startMatch),
    .o_stopMask   (stopMask),
    .o_stopMatch  (stopMatch),
    .o_rdPtr      (rdPtrLoad),
    .o_rdLoad     (rdLoad),
    .o_rdAdvance  (rdAdvance)
  );

  dbgMuxSel u_dbgMuxSel (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_hw       (i_hw),
    .i_lane0Sel (lane0Sel),
    .i_lane1Sel (lane1Sel),
    .o_debugBus (debugBus)
  );

  logicAnalyzer u_logicAnalyzer (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_debugBus    (debugBus),
    .i_arm         (arm),
    .i_clear       (clear),
    .i_startMask   (startMask),
    .i_startMatch  (startMatch),
    .i_stopMask    (stopMask),
    .i_stopMatch   (stopMatch),
    .o_laState     (laState),
    .o_traceActive (o_traceActive),
    .o_triggerOut  (o_triggerOut)
  );

  traceBuffer #(
    .DEPTH(`DFD_TRACE_DEPTH)
  ) u_traceBuffer (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_debugBus    (debugBus),
    .i_timeTick    (i_timeTick),
    .i_traceActive (o_traceActive),
    .i_clear       (clear),
    .i_rdPtr       (rdPtrLoad),
    .i_rdLoad      (rdLoad),
    .i_rdAdvance   (rdAdvance),
    .o_wrCount     (wrCount),
    .o_full        (full),
    .o_rdEntry     (rdEntry),
    .o_rdPtrValue  (rdPtrValue)
  );

endmodule

//--- hdl/logicAnalyzer.sv
// ********************
// dfdLite logic analyzer
// ********************

`include "dfdLite_params.svh"

module logicAnalyzer
  import dfdPkg::*;
(
  input  logic      clk,
  input  logic      i_rst,
  input  debugBus_t i_debugBus,
  input  logic      i_arm,
  input  logic      i_clear,
  input  debugBus_t i_startMask,
  input  debugBus_t i_startMatch,
  input  debugBus_t i_stopMask,
  input  debugBus_t i_stopMatch,
  output laState_e  o_laState,
  output logic      o_traceActive,
  output logic      o_triggerOut
);

  laState_e state;
  laState_e stateNext;
  logic     startHit;
  logic     stopHit;
  logic     trigger;

  // mask/match conditions on the current bus sample
  assign startHit = (i_debugBus & i_startMask) == (i_startMatch & i_startMask);
  assign stopHit  = (i_debugBus & i_stopMask) == (i_stopMatch & i_stopMask);

  // ********************
  // trace FSM
  // ********************

  always_comb begin
    stateNext = state;
    trigger   = 1'b0;
    if (i_clear) begin
      stateNext = LA_IDLE;
    end else begin
      case (state)
        LA_IDLE: begin
          if (i_arm) begin
            stateNext = LA_ARMED;
          end
        end
        LA_ARMED: begin
          if (startHit) begin
            stateNext = LA_TRACING;
            trigger   = 1'b1;
          end
        end
        LA_TRACING: begin
          if (stopHit) begin
            stateNext = LA_DONE;
          end
        end
        // done waits for clear
        default: stateNext = state;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state        <= LA_IDLE;
      o_triggerOut <= 1'b0;
    end else begin
      state        <= stateNext;
      o_triggerOut <= trigger;
    end
  end

  assign o_laState     = state;
  assign o_traceActive = (state == LA_TRACING);

  // only clear gets the analyzer out of done
  doneExitsToIdle : assert property (
    @(posedge clk) disable iff (i_rst)
    (state == LA_DONE) |=> (state inside {LA_DONE, LA_IDLE})
  );

endmodule

//--- hdl/traceBuffer.sv
// ********************
// dfdLite trace buffer
// ********************

`include "dfdLite_params.svh"

module traceBuffer
  import dfdPkg::*;
#(
  parameter int unsigned DEPTH = `DFD_TRACE_DEPTH,
  localparam int unsigned PTR_W = $clog2(DEPTH)
) (
  input  logic              clk,
  input  logic              i_rst,
  input  debugBus_t         i_debugBus,
  input  logic              i_timeTick,
  input  logic              i_traceActive,
  input  logic              i_clear,
  input  logic [PTR_W-1:0]  i_rdPtr,
  input  logic              i_rdLoad,
  input  logic              i_rdAdvance,
  output logic [PTR_W:0]    o_wrCount,
  output logic              o_full,
  output traceEntry_t       o_rdEntry,
  output logic [PTR_W-1:0]  o_rdPtrValue
);

  timestamp_t       tickCount;
  logic [PTR_W:0]   wrCount;
  logic [PTR_W-1:0] rdPtr;
  logic             wrEn;
  traceEntry_t      mem [DEPTH];

  assign o_full = (wrCount == (PTR_W + 1)'(DEPTH));
  // no back-pressure, writes just stop once full
  assign wrEn   = i_traceActive & ~o_full & ~i_clear;

  // ********************
  // counters and pointers
  // ********************

  always_ff @(posedge clk) begin
    if (i_rst) begin
      tickCount <= '0;
      wrCount   <= '0;
      rdPtr     <= '0;
    end else if (i_clear) begin
      tickCount <= '0;
      wrCount   <= '0;
      rdPtr     <= '0;
    end else begin
      if (i_timeTick) begin
        tickCount <= tickCount + 1'b1;
      end
      if (wrEn) begin
        wrCount <= wrCount + 1'b1;
      end
      // a load wins over an advance
      if (i_rdLoad) begin
        rdPtr <= i_rdPtr;
      end else if (i_rdAdvance) begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

  // ********************
  // entry memory
  // ********************

  // entry stamp is the count before this cycle's tick
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrCount[PTR_W-1:0]] <= '{stamp: tickCount, sample: i_debugBus};
    end
    o_rdEntry <= mem[rdPtr];
  end

  assign o_wrCount    = wrCount;
  assign o_rdPtrValue = rdPtr;

  // fill level stays within the memory
  countWithinDepth : assert property (
    @(posedge clk) disable iff (i_rst) wrCount <= (PTR_W + 1)'(DEPTH)
  );

endmodule

//--- verification/dfdTopTb.sv
// ********************
// dfdLite testbench
// ********************

`include "dfdLite_params.svh"

module dfdTopTb
  import dfdPkg::*;
();

  localparam int NUM_PHASES = 6;
  localparam int DEPTH = `DFD_TRACE_DEPTH;
  localparam logic [31:0] SEED = 32'h2ebc;
  localparam logic [3:0] LANE0 = 4'd3;
  localparam logic [3:0] LANE1 = 4'd9;

  logic                           clk;
  logic                           rst;
  hwGroup_t [`DFD_NUM_HW-1:0]     hw;
  logic                           timeTick;
  logic [`DFD_APB_ADDR_WIDTH-1:0] paddr;
  logic                           psel;
  logic                           penable;
  logic                           pwrite;
  logic [`DFD_APB_DATA_WIDTH-1:0] pwdata;
  logic                           pready;
  logic [`DFD_APB_DATA_WIDTH-1:0] prdata;
  logic                           pslverr;
  logic                           traceActive;
  logic                           triggerOut;

  logic [31:0] hwLfsr;
  logic [31:0] tickLfsr;
  int          ticksDriven;
  logic        tickClearReq;
  int          trigPulses;

  tbClock clockGen (.o_clk(clk));

  dfdTop i_dfdTop (
    .clk           (clk),
    .i_rst         (rst),
    .i_hw          (hw),
    .i_timeTick    (timeTick),
    .i_paddr       (paddr),
    .i_psel        (psel),
    .i_penable     (penable),
    .i_pwrite      (pwrite),
    .i_pwdata      (pwdata),
    .o_pready      (pready),
    .o_prdata      (prdata),
    .o_pslverr     (pslverr),
    .o_traceActive (traceActive),
    .o_triggerOut  (triggerOut)
  );

  // ********************
  // stimulus helpers
  // ********************

  // fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value  = {value[30:0], hwLfsr[31]};
      hwLfsr = lfsrNext(hwLfsr);
    end
  endtask

  // expected bus sample for held groups and selectors
  function automatic debugBus_t refEntry(input hwGroup_t [`DFD_NUM_HW-1:0] groups,
                                         input logic [3:0] sel0, input logic [3:0] sel1);
    debugBus_t bus;
    bus[`DFD_HW_WIDTH-1:0]               = groups[sel0];
    bus[2*`DFD_HW_WIDTH-1:`DFD_HW_WIDTH] = groups[sel1];
    return bus;
  endfunction

  task automatic driveNewGroups();
    logic [31:0] bits;
    @(negedge clk);
    for (int g = 0; g < `DFD_NUM_HW; g++) begin
      takeBits(`DFD_HW_WIDTH, bits);
      hw[g] = bits[`DFD_HW_WIDTH-1:0];
    end
  endtask

  // tick every cycle from its own LFSR, counted for the stamp bounds
  always @(negedge clk) begin
    if (tickClearReq) begin
      ticksDriven  = 0;
      tickClearReq = 1'b0;
    end
    timeTick = tickLfsr[31];
    tickLfsr = lfsrNext(tickLfsr);
    if (timeTick) ticksDriven++;
  end

  always @(negedge clk) begin
    if (triggerOut === 1'b1) trigPulses++;
  end

  // ********************
  // compare tasks
  // ********************

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkBus(input string name, input debugBus_t got, input debugBus_t exp);
    if (got !== exp) begin
      stopOnError($sformatf("ERROR time=%0t %s got 0x%08h expected 0x%08h",
                            $time, name, got, exp));
    end
  endtask

  task automatic checkState(input string name, input laState_e got, input laState_e exp);
    if (got !== exp) begin
      stopOnError($sformatf("ERROR time=%0t %s got %s expected %s",
                            $time, name, got.name(), exp.name()));
    end
  endtask

  task automatic checkCount(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      stopOnError($sformatf("ERROR time=%0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic checkStamp(input string name, input timestamp_t got,
                            input timestamp_t lo, input timestamp_t hi);
    if (got < lo || got > hi) begin
      stopOnError($sformatf("ERROR time=%0t %s got %0d expected %0d..%0d",
                            $time, name, got, lo, hi));
    end
  endtask

  // ********************
  // APB master
  // ********************

  task automatic apbAccess(input logic [11:0] addr, input logic write, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
    int waitCycles;
    @(negedge clk);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable    = 1'b1;
    waitCycles = 0;
    #1;
    while (pready !== 1'b1) begin
      waitCycles++;
      if (waitCycles > 4) stopOnError("APB transfer got no ready response");
      @(negedge clk);
      #1;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic regWrite(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apbAccess(addr, 1'b1, data, rd, err);
    checkCount($sformatf("o_pslverr writing 0x%03h", addr), err, 0);
  endtask

  task automatic regRead(input logic [11:0] addr, output logic [31:0] data);
    logic err;
    apbAccess(addr, 1'b0, '0, data, err);
    checkCount($sformatf("o_pslverr reading 0x%03h", addr), err, 0);
  endtask

  task automatic writeReadBack(input logic [11:0] addr, input logic [31:0] value,
                               input string name);
    logic [31:0] rd;
    regWrite(addr, value);
    regRead(addr, rd);
    checkBus(name, rd, value);
  endtask

  // ********************
  // status helpers
  // ********************

  task automatic readTrStatus(output logic [31:0] count, output logic full);
    logic [31:0] rd;
    regRead(`DFD_REG_TRSTATUS, rd);
    count = rd[6:0];
    full  = rd[8];
  endtask

  task automatic waitState(input laState_e exp);
    logic [31:0] rd;
    int          polls;
    polls = 0;
    regRead(`DFD_REG_LASTATUS, rd);
    while (laState_e'(rd[1:0]) != exp && polls < 20) begin
      polls++;
      regRead(`DFD_REG_LASTATUS, rd);
    end
    checkState("LASTATUS", laState_e'(rd[1:0]), exp);
  endtask

  task automatic waitFull();
    logic [31:0] count;
    logic        full;
    int          polls;
    polls = 0;
    readTrStatus(count, full);
    while (!full && polls < 40) begin
      polls++;
      readTrStatus(count, full);
    end
    checkCount("TRSTATUS full", full, 1);
  endtask

  task automatic waitTrigger(input int n);
    int cycles;
    cycles = 0;
    while (trigPulses < n && cycles < 40) begin
      @(negedge clk);
      cycles++;
    end
    checkCount("o_triggerOut pulses", trigPulses, n);
  endtask

  task automatic clearTrace();
    regWrite(`DFD_REG_LACTRL, 32'h2);
    // count ticks again from the edge after the clear pulse
    @(posedge clk);
    tickClearReq = 1'b1;
  endtask

  // stamps read before the sample, since the sample read advances the pointer
  task automatic readEntries(input debugBus_t exp, input int n);
    logic [31:0] rd;
    timestamp_t  lastStamp;
    timestamp_t  stamp;
    lastStamp = '0;
    regWrite(`DFD_REG_RDPTR, 32'h0);
    for (int i = 0; i < n; i++) begin
      regRead(`DFD_REG_TRTSTAMP, rd);
      stamp = rd[`DFD_TSTAMP_WIDTH-1:0];
      checkStamp($sformatf("entry %0d stamp", i), stamp, lastStamp, timestamp_t'(ticksDriven));
      lastStamp = stamp;
      regRead(`DFD_REG_TRDATA, rd);
      checkBus($sformatf("entry %0d sample", i), rd, exp);
    end
  endtask

  // ********************
  // test sequence
  // ********************

  initial begin
    debugBus_t   expBus;
    debugBus_t   newBus;
    logic [31:0] rd;
    logic        err;
    logic [31:0] count;
    logic [31:0] firstCount;
    logic        full;

    rst          = 1'b1;
    hw           = '0;
    timeTick     = 1'b0;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    hwLfsr       = SEED;
    tickLfsr     = SEED;
    ticksDriven  = 0;
    tickClearReq = 1'b0;
    trigPulses   = 0;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // register readback and slave errors
    driveNewGroups();
    writeReadBack(`DFD_REG_MUXSEL, {24'h0, LANE1, LANE0}, "MUXSEL");
    writeReadBack(`DFD_REG_STARTMASK, 32'hF0F0_1234, "STARTMASK");
    writeReadBack(`DFD_REG_STARTMATCH, 32'h0BAD_CAFE, "STARTMATCH");
    writeReadBack(`DFD_REG_STOPMASK, 32'h5A5A_00FF, "STOPMASK");
    writeReadBack(`DFD_REG_STOPMATCH, 32'h1357_9BDF, "STOPMATCH");
    apbAccess(12'h040, 1'b0, '0, rd, err);
    checkCount("o_pslverr on unmapped read", err, 1);
    apbAccess(`DFD_REG_LASTATUS, 1'b1, 32'h1, rd, err);
    checkCount("o_pslverr on LASTATUS write", err, 1);

    // armed with a start condition that cannot hit
    expBus = refEntry(hw, LANE0, LANE1);
    regWrite(`DFD_REG_STARTMASK, '1);
    regWrite(`DFD_REG_STARTMATCH, ~expBus);
    regWrite(`DFD_REG_STOPMASK, '1);
    regWrite(`DFD_REG_STOPMATCH, ~expBus);
    clearTrace();
    regWrite(`DFD_REG_LACTRL, 32'h1);
    repeat (20) @(negedge clk);
    waitState(LA_ARMED);
    readTrStatus(count, full);
    checkCount("TRSTATUS count while armed", count, 0);

    // start hit, buffer fills with the held sample
    regWrite(`DFD_REG_STARTMATCH, expBus);
    waitTrigger(1);
    waitState(LA_TRACING);
    waitFull();
    readEntries(expBus, DEPTH);

    // fresh trace, then stop on a new held value before the buffer fills
    clearTrace();
    regWrite(`DFD_REG_LACTRL, 32'h1);
    waitTrigger(2);
    driveNewGroups();
    newBus = refEntry(hw, LANE0, LANE1);
    regWrite(`DFD_REG_STOPMATCH, newBus);
    waitState(LA_DONE);
    readTrStatus(firstCount, full);
    readTrStatus(count, full);
    checkCount("TRSTATUS count after done", count, firstCount);
    checkCount("TRSTATUS full after done", full, 0);

    // trace without a stop until full
    regWrite(`DFD_REG_STARTMASK, 32'h0);
    regWrite(`DFD_REG_STOPMATCH, ~newBus);
    clearTrace();
    regWrite(`DFD_REG_LACTRL, 32'h1);
    waitTrigger(3);
    waitFull();
    readTrStatus(count, full);
    checkCount("TRSTATUS count when full", count, DEPTH);
    checkCount("o_traceActive when full", traceActive, 1);
    waitState(LA_TRACING);

    // stamp ordering and bounds, then clear
    readEntries(newBus, DEPTH);
    clearTrace();
    waitState(LA_IDLE);
    readTrStatus(count, full);
    checkCount("TRSTATUS count after clear", count, 0);
    checkCount("o_traceActive after clear", traceActive, 0);

    $display("*** PASSED ***");
    $finish;
  end

  // run limit scales with the number of phases
  initial begin
    repeat (NUM_PHASES * 200 + 1000) @(posedge clk);
    stopOnError("watchdog timeout, the test sequence did not finish in time");
  end

endmodule

//--- verification/tbClock.sv
// ********************
// testbench clock
// ********************

module tbClock #(
  parameter int HALF_PERIOD = 5
) (
  output logic o_clk
);

  initial o_clk = 1'b0;

  // 10 unit period
  always #HALF_PERIOD o_clk = ~o_clk;

endmodule
